// File: Makefile
# Verilator build and run for the statistics block testbench

VERILATOR  ?= verilator
TOP        ?= tb_stats_top
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_clock_gen.sv
// Testbench clock and reset source making a 10 ns clock and a two-cycle reset
module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

    always #5 clk = ~clk;

endmodule

// File: dv/tb_stats_top.sv
// Testbench for the statistics top level checking random traffic against per-channel totals
module tb_stats_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CNT = 8;
    localparam int INC_W = 8;
    localparam int UPDATE_PERIOD = 64;
    localparam int FLUSH_CYCLES = 2 * CNT * (CNT + 1) + 200;

    logic                 clk;
    logic                 rst;
    logic [CNT*INC_W-1:0] stat_inc;
    logic [CNT-1:0]       stat_valid;
    logic                 update;
    logic                 rd_en;
    logic [3:0]           rd_addr;
    logic [31:0]          rd_data;
    logic                 rd_valid;

    logic [15:0] lfsr;
    logic [31:0] totals [CNT];
    logic [31:0] last_rd [CNT];
    bit          traffic_on;
    bit          full_load;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    stats_top #(
        .CNT           (CNT),
        .INC_W         (INC_W),
        .UPDATE_PERIOD (UPDATE_PERIOD)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .stat_inc   (stat_inc),
        .stat_valid (stat_valid),
        .update     (update),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // Advance one clock and drive the next input set that the model counts
    task automatic next_cycle();
        logic [31:0]      v;
        logic [INC_W-1:0] inc;
        @(posedge clk);
        #1;
        rd_en = 1'b0;
        update = 1'b0;
        for (int ch = 0; ch < CNT; ch++) begin
            if (full_load) begin
                stat_valid[ch] = 1'b1;
                inc = 8'hff;
            end else if (traffic_on) begin
                v = take_bits(9);
                stat_valid[ch] = v[8];
                inc = v[7:0];
            end else begin
                stat_valid[ch] = 1'b0;
                inc = '0;
            end
            stat_inc[ch*INC_W +: INC_W] = inc;
            if (stat_valid[ch]) begin
                totals[ch] = totals[ch] + 32'(inc);
            end
        end
    endtask

    task automatic read_counter(input int ch, output logic [31:0] value, output bit ok);
        int lat;
        ok = 1'b0;
        value = '0;
        lat = 0;
        rd_en = 1'b1;
        rd_addr = 4'(ch);
        while (!ok && lat < 8) begin
            next_cycle();
            lat++;
            if (rd_valid) begin
                ok = 1'b1;
                value = rd_data;
            end
        end
        if (!ok) begin
            $display("Read response for channel %0d did not arrive", ch);
            test_errors++;
        end else if (lat != 2) begin
            $display("Read response for channel %0d came after %0d cycles, not 2", ch, lat);
            test_errors++;
            ok = 1'b0;
        end
        next_cycle();
        if (rd_valid) begin
            $display("rd_valid stayed high after the read of channel %0d", ch);
            test_errors++;
        end
    endtask

    task automatic check_all();
        logic [31:0] got;
        bit          ok;
        for (int ch = 0; ch < CNT; ch++) begin
            read_counter(ch, got, ok);
            if (ok && got !== totals[ch]) begin
                $display("Error rd_data ch=%0h expected %08h got %08h", ch, totals[ch], got);
                test_errors++;
            end
            if (ok) begin
                last_rd[ch] = got;
            end
        end
    endtask

    // Stop traffic, request an update and give the sweep time to drain
    task automatic quiesce();
        traffic_on = 1'b0;
        full_load = 1'b0;
        next_cycle();
        update = 1'b1;
        for (int i = 0; i < FLUSH_CYCLES; i++) begin
            next_cycle();
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("Test %s: ok", name);
            tests_passed++;
        end else begin
            $display("Test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        logic [31:0] got;
        logic [31:0] issued;
        logic [31:0] v;
        bit          ok;
        int          wait_cnt;
        int          ch;

        lfsr = 16'd29176;
        stat_inc = '0;
        stat_valid = '0;
        update = 1'b0;
        rd_en = 1'b0;
        rd_addr = '0;
        traffic_on = 1'b0;
        full_load = 1'b0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < CNT; i++) begin
            totals[i] = '0;
            last_rd[i] = '0;
        end

        wait_cnt = 0;
        next_cycle();
        while (rst && wait_cnt < 20) begin
            next_cycle();
            wait_cnt++;
        end
        if (rst) begin
            $display("Reset did not release within 20 cycles");
            test_errors++;
        end
        // Counter RAM clear sweep
        for (int i = 0; i < 4 * CNT; i++) begin
            next_cycle();
        end
        check_all();
        finish_test("reset_clear");

        traffic_on = 1'b1;
        for (int i = 0; i < 2000; i++) begin
            next_cycle();
        end
        quiesce();
        check_all();
        finish_test("random_update_flush");

        traffic_on = 1'b1;
        for (int i = 0; i < 500; i++) begin
            next_cycle();
        end
        traffic_on = 1'b0;
        for (int i = 0; i < UPDATE_PERIOD + FLUSH_CYCLES; i++) begin
            next_cycle();
        end
        check_all();
        finish_test("periodic_update");

        traffic_on = 1'b1;
        for (int i = 0; i < 1500; i++) begin
            next_cycle();
            v = take_bits(3);
            if (v[2:0] == 3'd0) begin
                ch = int'(take_bits(3)) % CNT;
                issued = totals[ch];
                read_counter(ch, got, ok);
                if (ok && got > issued) begin
                    $display("Error rd_data ch=%0h expected at most %08h got %08h",
                             ch, issued, got);
                    test_errors++;
                end
                if (ok && got < last_rd[ch]) begin
                    $display("Error rd_data ch=%0h expected at least %08h got %08h",
                             ch, last_rd[ch], got);
                    test_errors++;
                end
                if (ok) begin
                    last_rd[ch] = got;
                end
            end
        end
        quiesce();
        check_all();
        finish_test("reads_under_traffic");

        full_load = 1'b1;
        for (int i = 0; i < 500; i++) begin
            next_cycle();
            if (i % 50 == 25) begin
                update = 1'b1;
            end
        end
        quiesce();
        check_all();
        finish_test("maximum_load");

        $display("Tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
verilog/stats_width_pkg.sv
verilog/stats_bank_pkg.sv
verilog/stats_stream_if.sv
verilog/stats_collect.sv
verilog/stats_counter.sv
verilog/stats_top.sv
dv/tb_clock_gen.sv
dv/tb_stats_top.sv

// File: verilog/stats_bank_pkg.sv
// Counter bank constants for read timing and the post-reset clear sweep
package stats_bank_pkg;

    // Cycles from rd_en to rd_valid
    localparam int RD_LATENCY = 2;

    // Clear sweep time spent on each counter entry
    localparam int CLEAR_CYCLES_PER_ENTRY = 1;

endpackage

// File: verilog/stats_collect.sv
// Statistics collector that sums per-channel increments and emits them as stream messages
module stats_collect #(
    parameter int CNT = 8,
    parameter int INC_W = stats_width_pkg::INC_W,
    parameter int UPDATE_PERIOD = 1024
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [INC_W-1:0] stat_inc [CNT],
    input  logic [CNT-1:0]   stat_valid,
    input  logic             update,
    stats_stream_if.src      m_stat
);

    localparam int STREAM_W = stats_width_pkg::STREAM_W;
    localparam int ID_W = stats_width_pkg::ID_W;
    localparam int CNT_W = (CNT > 1) ? $clog2(CNT) : 1;
    localparam int ACC_W = INC_W + $clog2(CNT) + 1;
    localparam int PERIOD_W = $clog2(UPDATE_PERIOD + 1);

    logic                wr_phase;
    logic [CNT_W-1:0]    count_reg;
    logic [PERIOD_W-1:0] period_reg;
    logic                zero_reg;
    logic [CNT-1:0]      mark_reg;

    logic [CNT_W-1:0]    count_next;
    logic [PERIOD_W-1:0] period_next;
    logic                zero_next;
    logic [CNT-1:0]      mark_next;

    logic [STREAM_W-1:0] data_reg;
    logic [ID_W-1:0]     id_reg;
    logic                valid_reg;
    logic [STREAM_W-1:0] data_next;
    logic [ID_W-1:0]     id_next;
    logic                valid_next;

    logic [ACC_W-1:0]    acc [CNT];
    logic [CNT-1:0]      acc_clear;

    logic [STREAM_W-1:0] mem [CNT];
    logic [STREAM_W-1:0] mem_rd_data;
    logic [STREAM_W-1:0] mem_wr_data;
    logic [STREAM_W-1:0] part_sum;

    assign m_stat.data = data_reg;
    assign m_stat.id = id_reg;
    assign m_stat.valid = valid_reg;

    // Accumulators are reloaded at their write slot so they only span one pass
    for (genvar n = 0; n < CNT; n++) begin : g_acc
        always_ff @(posedge clk) begin
            if (rst) begin
                acc[n] <= '0;
            end else if (acc_clear[n]) begin
                acc[n] <= stat_valid[n] ? ACC_W'(stat_inc[n]) : '0;
            end else if (stat_valid[n]) begin
                acc[n] <= acc[n] + ACC_W'(stat_inc[n]);
            end
        end
    end

    // Memory holds garbage until the first pass has written every entry
    assign part_sum = zero_reg ? STREAM_W'(acc[count_reg])
                               : mem_rd_data + STREAM_W'(acc[count_reg]);

    always_comb begin
        count_next = count_reg;
        zero_next = zero_reg;
        mark_next = mark_reg;
        period_next = period_reg;

        data_next = data_reg;
        id_next = id_reg;
        valid_next = valid_reg && !m_stat.ready;

        acc_clear = '0;
        mem_wr_data = part_sum;

        if (wr_phase) begin
            acc_clear[count_reg] = 1'b1;
            if (!valid_reg && mark_reg[count_reg]) begin
                mark_next[count_reg] = 1'b0;
                mem_wr_data = '0;
                data_next = part_sum;
                id_next = ID_W'(count_reg);
                valid_next = part_sum != '0;
            end

            if (count_reg == CNT_W'(CNT - 1)) begin
                count_next = '0;
                zero_next = 1'b0;
            end else begin
                count_next = count_reg + 1'b1;
            end
        end

        if (period_reg == '0) begin
            period_next = PERIOD_W'(UPDATE_PERIOD - 1);
            mark_next = '1;
        end else begin
            period_next = period_reg - 1'b1;
        end

        if (update) begin
            mark_next = '1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_phase <= 1'b0;
            count_reg <= '0;
            period_reg <= PERIOD_W'(UPDATE_PERIOD - 1);
            zero_reg <= 1'b1;
            mark_reg <= '0;
            valid_reg <= 1'b0;
        end else begin
            wr_phase <= !wr_phase;
            count_reg <= count_next;
            period_reg <= period_next;
            zero_reg <= zero_next;
            mark_reg <= mark_next;
            valid_reg <= valid_next;
        end
    end

    always_ff @(posedge clk) begin
        data_reg <= data_next;
        id_reg <= id_next;
    end

    always_ff @(posedge clk) begin
        if (wr_phase) begin
            mem[count_reg] <= mem_wr_data;
        end else begin
            mem_rd_data <= mem[count_reg];
        end
    end

    a_stream_hold: assert property (
        @(posedge clk) disable iff (rst)
        m_stat.valid && !m_stat.ready |=>
            m_stat.valid && $stable(m_stat.data) && $stable(m_stat.id)
    );

    a_no_zero_msg: assert property (
        @(posedge clk) disable iff (rst)
        m_stat.valid |-> m_stat.data != '0
    );

endmodule

// File: verilog/stats_counter.sv
// Counter bank with post-reset clear, read-modify-write of messages and a fixed-latency read port
module stats_counter #(
    parameter int CNT = 8
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rd_en,
    input  logic [stats_width_pkg::ID_W-1:0]    rd_addr,
    output logic [stats_width_pkg::COUNT_W-1:0] rd_data,
    output logic                                rd_valid,
    stats_stream_if.snk                         s_stat
);

    localparam int STREAM_W = stats_width_pkg::STREAM_W;
    localparam int COUNT_W = stats_width_pkg::COUNT_W;
    localparam int RD_LAT = stats_bank_pkg::RD_LATENCY;
    localparam int CLR_PER = stats_bank_pkg::CLEAR_CYCLES_PER_ENTRY;
    localparam int CLR_TOTAL = CNT * CLR_PER;
    localparam int CLR_W = $clog2(CLR_TOTAL + 1);
    localparam int ADDR_W = (CNT > 1) ? $clog2(CNT) : 1;

    logic [COUNT_W-1:0]  ram [CNT];
    logic [COUNT_W-1:0]  ram_q;

    logic [CLR_W-1:0]    clear_cnt;
    logic                clearing;
    logic [ADDR_W-1:0]   clear_addr;

    logic                accept;
    logic                wr_pending;
    logic [ADDR_W-1:0]   wr_addr;
    logic [STREAM_W-1:0] inc_reg;
    logic [ADDR_W-1:0]   ram_rd_addr;

    logic [RD_LAT-1:0]   rd_pipe;

    assign clearing = clear_cnt != '0;
    assign clear_addr = ADDR_W'((clear_cnt - 1'b1) / CLR_PER);

    // One message in flight, and a host read takes the RAM read slot
    assign s_stat.ready = !clearing && !wr_pending && !rd_en;
    assign accept = s_stat.valid && s_stat.ready;

    assign ram_rd_addr = rd_en ? ADDR_W'(rd_addr) : ADDR_W'(s_stat.id);

    always_ff @(posedge clk) begin
        if (rst) begin
            clear_cnt <= CLR_W'(CLR_TOTAL);
            wr_pending <= 1'b0;
            rd_pipe <= '0;
        end else begin
            if (clearing) begin
                clear_cnt <= clear_cnt - 1'b1;
            end
            wr_pending <= accept;
            rd_pipe <= {rd_pipe[RD_LAT-2:0], rd_en};
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_addr <= ADDR_W'(s_stat.id);
            inc_reg <= s_stat.data;
        end
    end

    // Read-before-write RAM so the sum uses the value read on the accept cycle
    always_ff @(posedge clk) begin
        if (clearing) begin
            ram[clear_addr] <= '0;
        end else if (wr_pending) begin
            ram[wr_addr] <= ram_q + COUNT_W'(inc_reg);
        end

        if (rd_en || accept) begin
            ram_q <= ram[ram_rd_addr];
        end
    end

    // Second stage of the host read pipeline
    always_ff @(posedge clk) begin
        if (rd_pipe[0]) begin
            rd_data <= ram_q;
        end
    end

    assign rd_valid = rd_pipe[RD_LAT-1];

    a_id_range: assert property (
        @(posedge clk) disable iff (rst)
        s_stat.valid && s_stat.ready |-> s_stat.id < CNT
    );

    a_rd_latency: assert property (
        @(posedge clk) disable iff (rst)
        rd_en |-> ##RD_LAT rd_valid
    );

    a_rd_no_spurious: assert property (
        @(posedge clk) disable iff (rst)
        rd_valid |-> $past(rd_en, RD_LAT)
    );

endmodule

// File: verilog/stats_stream_if.sv
// Increment message stream from the collector to the counter bank with a valid/ready handshake
interface stats_stream_if;

    logic [stats_width_pkg::STREAM_W-1:0] data;
    logic [stats_width_pkg::ID_W-1:0]     id;
    logic                                 valid;
    logic                                 ready;

    modport src (
        output data,
        output id,
        output valid,
        input  ready
    );

    modport snk (
        input  data,
        input  id,
        input  valid,
        output ready
    );

endinterface

// File: verilog/stats_top.sv
// Statistics top level joining the collector to the counter bank over the increment stream
module stats_top #(
    parameter int CNT = 8,
    parameter int INC_W = stats_width_pkg::INC_W,
    parameter int UPDATE_PERIOD = 1024
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [CNT*INC_W-1:0]                stat_inc,
    input  logic [CNT-1:0]                      stat_valid,
    input  logic                                update,
    input  logic                                rd_en,
    input  logic [stats_width_pkg::ID_W-1:0]    rd_addr,
    output logic [stats_width_pkg::COUNT_W-1:0] rd_data,
    output logic                                rd_valid
);

    logic [INC_W-1:0] stat_inc_ch [CNT];

    // Channel n occupies bits n*INC_W upward
    for (genvar n = 0; n < CNT; n++) begin : g_slice
        assign stat_inc_ch[n] = stat_inc[n*INC_W +: INC_W];
    end

    stats_stream_if stat_if ();

    stats_collect #(
        .CNT           (CNT),
        .INC_W         (INC_W),
        .UPDATE_PERIOD (UPDATE_PERIOD)
    ) u_collect (
        .clk        (clk),
        .rst        (rst),
        .stat_inc   (stat_inc_ch),
        .stat_valid (stat_valid),
        .update     (update),
        .m_stat     (stat_if.src)
    );

    stats_counter #(
        .CNT (CNT)
    ) u_counter (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .s_stat   (stat_if.snk)
    );

endmodule

// File: verilog/stats_width_pkg.sv
// Statistics word widths shared by the collector, the stream and the counter bank
package stats_width_pkg;

    // One channel increment as presented at the inputs
    localparam int INC_W = 8;

    // Increment word on the stream and width of the partial-sum memory
    localparam int STREAM_W = 16;

    // One counter in the bank that wraps on overflow
    localparam int COUNT_W = 32;

    // Channel id on the stream that bounds the channel count to 16
    localparam int ID_W = 4;

endpackage
